/* CorePkg.sv */
package CorePkg;

	parameter int XLEN = 32;
	parameter int RegNumWidth = 5;

	// Next-pc selection
	typedef enum logic [1:0] {
		PcStep = 2'd0, // Fall through to pc + 4
		PcJump = 2'd1, // Branch or jump target
		PcHold = 2'd2 // Only right after reset
	} PcOp;

	// Major opcodes implemented by the core
	typedef enum logic [6:0] {
		OpLoad = 7'b0000011,
		OpImm = 7'b0010011,
		OpAuipc = 7'b0010111,
		OpStore = 7'b0100011,
		OpReg = 7'b0110011,
		OpLui = 7'b0110111,
		OpBranch = 7'b1100011,
		OpJalr = 7'b1100111,
		OpJal = 7'b1101111
	} Opcode;

	// ALU func3 codes
	localparam logic [2:0] F3Add = 3'b000; // add, sub, addi
	localparam logic [2:0] F3Sll = 3'b001;
	localparam logic [2:0] F3Slt = 3'b010;
	localparam logic [2:0] F3Sltu = 3'b011;
	localparam logic [2:0] F3Xor = 3'b100;
	localparam logic [2:0] F3Srl = 3'b101; // srl and sra
	localparam logic [2:0] F3Or = 3'b110;
	localparam logic [2:0] F3And = 3'b111;

	// Branch func3 codes
	localparam logic [2:0] F3Beq = 3'b000;
	localparam logic [2:0] F3Bne = 3'b001;
	localparam logic [2:0] F3Blt = 3'b100;
	localparam logic [2:0] F3Bge = 3'b101;
	localparam logic [2:0] F3Bltu = 3'b110;
	localparam logic [2:0] F3Bgeu = 3'b111;

	typedef struct packed {
		logic [6:0] func7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		Opcode opcode;
	} RType;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] rd;
		Opcode opcode;
	} IType;

	typedef struct packed {
		logic [6:0] immHi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [4:0] immLo;
		Opcode opcode;
	} SType;

	typedef struct packed {
		logic imm12;
		logic [5:0] imm10to5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] func3;
		logic [3:0] imm4to1;
		logic imm11;
		Opcode opcode;
	} BType;

	typedef struct packed {
		logic [19:0] imm; // Upper 20 bits of the result
		logic [4:0] rd;
		Opcode opcode;
	} UType;

	typedef struct packed {
		logic imm20;
		logic [9:0] imm10to1;
		logic imm11;
		logic [7:0] imm19to12;
		logic [4:0] rd;
		Opcode opcode;
	} JType;

	// One instruction word, six ways to read it
	typedef union packed {
		RType rType;
		IType iType;
		SType sType;
		BType bType;
		UType uType;
		JType jType;
	} InstrWord;

	typedef struct packed {
		logic valid;
		Opcode opcode;
		logic [2:0] func3;
		logic [6:0] func7;
		logic [XLEN-1:0] operand0; // rs1 after forwarding
		logic [XLEN-1:0] operand1; // rs2 after forwarding
		logic [XLEN-1:0] imm;
		logic [XLEN-1:0] pc;
		logic [RegNumWidth-1:0] rd; // Zero when nothing is written
	} DecodeOut;

	typedef struct packed {
		logic isLoad;
		logic isStore;
		logic [RegNumWidth-1:0] rd;
		logic [XLEN-1:0] result; // ALU result or memory address
		logic [XLEN-1:0] storeData;
	} MemStage;

	typedef struct packed {
		logic enable;
		logic [RegNumWidth-1:0] rd;
		logic [XLEN-1:0] data;
	} WriteBack;

	typedef enum logic [1:0] {
		FwdNone = 2'd0,
		FwdExec = 2'd1,
		FwdMem = 2'd2,
		FwdWb = 2'd3
	} FwdSel;

endpackage

/* Decode.sv */
`timescale 1ns/10ps
module Decode #(
	parameter int XLEN = CorePkg::XLEN
) (
	input logic clk,
	input logic reset,
	input CorePkg::InstrWord instr,
	input logic [XLEN-1:0] pc,
	input logic flush,
	input CorePkg::FwdSel fwdSel0,
	input CorePkg::FwdSel fwdSel1,
	input logic [XLEN-1:0] execResult,
	input logic [XLEN-1:0] memResult,
	input logic [XLEN-1:0] wbResult,
	output logic [CorePkg::RegNumWidth-1:0] regNum0,
	output logic [CorePkg::RegNumWidth-1:0] regNum1,
	input logic [XLEN-1:0] regReadData0,
	input logic [XLEN-1:0] regReadData1,
	output CorePkg::DecodeOut decodeOut
);

	import CorePkg::*;

	Opcode opcode;
	logic [XLEN-1:0] imm;
	logic [RegNumWidth-1:0] rd;
	logic [XLEN-1:0] operand0;
	logic [XLEN-1:0] operand1;

	function automatic logic [XLEN-1:0] pickOperand(
		input FwdSel sel,
		input logic [XLEN-1:0] regData,
		input logic [XLEN-1:0] exData,
		input logic [XLEN-1:0] meData,
		input logic [XLEN-1:0] wbData
	);
		case (sel)
			FwdExec:
				return exData;
			FwdMem:
				return meData;
			FwdWb:
				return wbData;
			default:
				return regData;
		endcase
	endfunction

	assign opcode = instr.rType.opcode;
	assign regNum0 = instr.rType.rs1;
	assign regNum1 = instr.rType.rs2;

	// Immediate format follows the opcode
	always_comb
	begin
		case (opcode)
			OpImm, OpJalr, OpLoad:
				imm = {{(XLEN-12){instr.iType.imm[11]}}, instr.iType.imm};
			OpStore:
				imm = {{(XLEN-12){instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
			OpBranch:
				imm = {{(XLEN-12){instr.bType.imm12}}, instr.bType.imm11,
					instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
			OpLui, OpAuipc:
				imm = XLEN'({instr.uType.imm, 12'b0});
			OpJal:
				imm = {{(XLEN-20){instr.jType.imm20}}, instr.jType.imm19to12,
					instr.jType.imm11, instr.jType.imm10to1, 1'b0};
			default:
				imm = '0;
		endcase
	end

	// Stores and branches carry rd zero so nothing downstream writes
	always_comb
	begin
		case (opcode)
			OpReg, OpImm, OpLui, OpAuipc, OpJal, OpJalr, OpLoad:
				rd = instr.rType.rd;
			default:
				rd = '0;
		endcase
	end

	assign operand0 = pickOperand(fwdSel0, regReadData0, execResult, memResult, wbResult);
	assign operand1 = pickOperand(fwdSel1, regReadData1, execResult, memResult, wbResult);

	always_ff @(posedge clk)
	begin
		decodeOut.opcode <= opcode;
		decodeOut.func3 <= instr.rType.func3;
		decodeOut.func7 <= instr.rType.func7;
		decodeOut.operand0 <= operand0;
		decodeOut.operand1 <= operand1;
		decodeOut.imm <= imm;
		decodeOut.pc <= pc;
		decodeOut.rd <= rd;
		if (reset)
			decodeOut.valid <= 1'b0;
		else
			decodeOut.valid <= !flush; // Squash the wrong-path fetch
	end

endmodule

/* Execute.sv */
`timescale 1ns/10ps
module Execute #(
	parameter int XLEN = CorePkg::XLEN
) (
	input logic clk,
	input logic reset,
	input CorePkg::DecodeOut decodeOut,
	input logic [XLEN-1:0] memReadData,
	output logic [XLEN-1:0] memAddr,
	output logic [XLEN-1:0] memWriteData,
	output logic memWrite,
	output logic memRead,
	output CorePkg::PcOp pcOp,
	output logic [XLEN-1:0] pcWriteData,
	output logic flush,
	output logic [XLEN-1:0] execResult,
	output logic [XLEN-1:0] memResult,
	output logic [CorePkg::RegNumWidth-1:0] execRd,
	output logic [CorePkg::RegNumWidth-1:0] memRd,
	output CorePkg::WriteBack writeBack
);

	import CorePkg::*;

	localparam int ShiftWidth = $clog2(XLEN);

	logic [XLEN-1:0] aluB;
	logic [XLEN-1:0] aluOut;
	logic [XLEN-1:0] result;
	logic [XLEN-1:0] linkAddr;
	logic [XLEN-1:0] jalrSum;
	logic [ShiftWidth-1:0] shamt;
	logic isRegOp;
	logic branchTrue;
	logic taken;
	logic pcRun; // Low for one cycle after reset
	MemStage memStage;

	assign isRegOp = decodeOut.opcode == OpReg;
	assign aluB = isRegOp ? decodeOut.operand1 : decodeOut.imm;
	assign shamt = aluB[ShiftWidth-1:0];
	assign linkAddr = decodeOut.pc + XLEN'(4);
	assign jalrSum = decodeOut.operand0 + decodeOut.imm;

	always_comb
	begin
		case (decodeOut.func3)
			F3Add:
				if (isRegOp && decodeOut.func7[5])
					aluOut = decodeOut.operand0 - aluB; // sub
				else
					aluOut = decodeOut.operand0 + aluB;
			F3Sll:
				aluOut = decodeOut.operand0 << shamt;
			F3Slt:
				aluOut = XLEN'($signed(decodeOut.operand0) < $signed(aluB));
			F3Sltu:
				aluOut = XLEN'(decodeOut.operand0 < aluB);
			F3Xor:
				aluOut = decodeOut.operand0 ^ aluB;
			F3Srl:
				if (decodeOut.func7[5])
					aluOut = $signed(decodeOut.operand0) >>> shamt; // sra, srai
				else
					aluOut = decodeOut.operand0 >> shamt;
			F3Or:
				aluOut = decodeOut.operand0 | aluB;
			F3And:
				aluOut = decodeOut.operand0 & aluB;
			default:
				aluOut = '0;
		endcase
	end

	always_comb
	begin
		case (decodeOut.opcode)
			OpLui:
				result = decodeOut.imm;
			OpAuipc:
				result = decodeOut.pc + decodeOut.imm;
			OpJal, OpJalr:
				result = linkAddr;
			OpLoad, OpStore:
				result = jalrSum; // Effective address
			default:
				result = aluOut;
		endcase
	end

	always_comb
	begin
		case (decodeOut.func3)
			F3Beq:
				branchTrue = decodeOut.operand0 == decodeOut.operand1;
			F3Bne:
				branchTrue = decodeOut.operand0 != decodeOut.operand1;
			F3Blt:
				branchTrue = $signed(decodeOut.operand0) < $signed(decodeOut.operand1);
			F3Bge:
				branchTrue = $signed(decodeOut.operand0) >= $signed(decodeOut.operand1);
			F3Bltu:
				branchTrue = decodeOut.operand0 < decodeOut.operand1;
			F3Bgeu:
				branchTrue = decodeOut.operand0 >= decodeOut.operand1;
			default:
				branchTrue = 1'b0;
		endcase
	end

	assign taken = decodeOut.valid && (decodeOut.opcode == OpJal || decodeOut.opcode == OpJalr
		|| (decodeOut.opcode == OpBranch && branchTrue));

	always_ff @(posedge clk)
	begin
		if (reset)
			pcRun <= 1'b0;
		else
			pcRun <= 1'b1;
	end

	assign pcOp = !pcRun ? PcHold : (taken ? PcJump : PcStep);
	assign pcWriteData = (decodeOut.opcode == OpJalr) ? {jalrSum[XLEN-1:1], 1'b0}
		: decodeOut.pc + decodeOut.imm;
	assign flush = taken || !pcRun; // Held pc must not decode twice

	assign execResult = result;
	assign execRd = decodeOut.valid ? decodeOut.rd : '0;

	always_ff @(posedge clk)
	begin
		memStage.result <= result;
		memStage.storeData <= decodeOut.operand1;
		if (reset)
		begin
			memStage.isLoad <= 1'b0;
			memStage.isStore <= 1'b0;
			memStage.rd <= '0;
		end
		else
		begin
			memStage.isLoad <= decodeOut.valid && decodeOut.opcode == OpLoad;
			memStage.isStore <= decodeOut.valid && decodeOut.opcode == OpStore;
			memStage.rd <= execRd;
		end
	end

	// Data port, memory answers in the same cycle
	assign memAddr = memStage.result;
	assign memWriteData = memStage.storeData;
	assign memWrite = memStage.isStore;
	assign memRead = memStage.isLoad;
	assign memResult = memStage.isLoad ? memReadData : memStage.result;
	assign memRd = memStage.rd;

	always_ff @(posedge clk)
	begin
		writeBack.data <= memResult;
		if (reset)
		begin
			writeBack.enable <= 1'b0;
			writeBack.rd <= '0;
		end
		else
		begin
			writeBack.enable <= memStage.rd != '0;
			writeBack.rd <= memStage.rd;
		end
	end

endmodule

/* Forward.sv */
`timescale 1ns/10ps
module Forward (
	input logic [CorePkg::RegNumWidth-1:0] regNum0,
	input logic [CorePkg::RegNumWidth-1:0] regNum1,
	input logic [CorePkg::RegNumWidth-1:0] execRd, // Zero when stage is empty
	input logic [CorePkg::RegNumWidth-1:0] memRd,
	input logic [CorePkg::RegNumWidth-1:0] wbRd,
	output CorePkg::FwdSel fwdSel0,
	output CorePkg::FwdSel fwdSel1
);

	import CorePkg::*;

	// Youngest producer wins
	function automatic FwdSel pickSource(
		input logic [RegNumWidth-1:0] srcNum,
		input logic [RegNumWidth-1:0] exNum,
		input logic [RegNumWidth-1:0] meNum,
		input logic [RegNumWidth-1:0] wbNum
	);
		if (srcNum == '0)
			return FwdNone; // x0 needs no bypass
		else if (srcNum == exNum)
			return FwdExec;
		else if (srcNum == meNum)
			return FwdMem;
		else if (srcNum == wbNum)
			return FwdWb; // Register write lands at the end of this cycle
		else
			return FwdNone;
	endfunction

	assign fwdSel0 = pickSource(regNum0, execRd, memRd, wbRd);
	assign fwdSel1 = pickSource(regNum1, execRd, memRd, wbRd);

endmodule

/* Makefile */
TOP = RiscCoreTb

all: run

build:
	verilator --binary --assert -f RiscCore.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q -F '*** TEST PASSED ***'

lint:
	verilator --lint-only -Wall --timing -f RiscCore.f --top-module RiscCore

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean

/* PcCounter.sv */
`timescale 1ns/10ps
module PcCounter #(
	parameter int XLEN = CorePkg::XLEN
) (
	input logic clk,
	input logic reset,
	input CorePkg::PcOp pcOp,
	input logic [XLEN-1:0] pcWriteData,
	output logic [XLEN-1:0] pc
);

	import CorePkg::*;

	logic [XLEN-1:0] pcNext;

	always_comb
	begin
		case (pcOp)
			PcStep:
				pcNext = pc + XLEN'(4); // Sequential fetch
			PcJump:
				pcNext = pcWriteData; // Redirect from execute
			PcHold:
				pcNext = pc;
			default:
				pcNext = pc;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			pc <= '0; // Boot address
		else
			pc <= pcNext;
	end

endmodule

/* RegsFile.sv */
`timescale 1ns/10ps
module RegsFile #(
	parameter int XLEN = CorePkg::XLEN
) (
	input logic clk,
	input logic reset,
	input logic [CorePkg::RegNumWidth-1:0] regNum0,
	input logic [CorePkg::RegNumWidth-1:0] regNum1,
	output logic [XLEN-1:0] regReadData0,
	output logic [XLEN-1:0] regReadData1,
	input CorePkg::WriteBack writeBack
);

	import CorePkg::*;

	localparam int RegCount = 2 ** RegNumWidth;

	logic [XLEN-1:0] regs [RegCount];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < RegCount; i++)
				regs[i] <= '0;
		end
		else if (writeBack.enable && writeBack.rd != '0)
			regs[writeBack.rd] <= writeBack.data; // x0 is never written
	end

	// Asynchronous read, x0 hardwired to zero
	assign regReadData0 = (regNum0 == '0) ? '0 : regs[regNum0];
	assign regReadData1 = (regNum1 == '0) ? '0 : regs[regNum1];

endmodule

/* RiscCore.f */
CorePkg.sv
PcCounter.sv
RegsFile.sv
Forward.sv
Decode.sv
Execute.sv
RiscCore.sv
RiscCoreTb.sv

/* RiscCore.sv */
`timescale 1ns/10ps
module RiscCore #(
	parameter int XLEN = CorePkg::XLEN
) (
	input logic clk,
	input logic reset,
	output logic [XLEN-1:0] pc,
	input logic [31:0] instr, // From instruction ROM, same cycle
	output logic [XLEN-1:0] memAddr,
	output logic [XLEN-1:0] memWriteData,
	output logic memWrite,
	output logic memRead,
	input logic [XLEN-1:0] memReadData
);

	import CorePkg::*;

	PcOp pcOp;
	logic [XLEN-1:0] pcWriteData;
	logic flush;
	logic [RegNumWidth-1:0] regNum0;
	logic [RegNumWidth-1:0] regNum1;
	logic [XLEN-1:0] regReadData0;
	logic [XLEN-1:0] regReadData1;
	FwdSel fwdSel0;
	FwdSel fwdSel1;
	logic [XLEN-1:0] execResult;
	logic [XLEN-1:0] memResult;
	logic [RegNumWidth-1:0] execRd;
	logic [RegNumWidth-1:0] memRd;
	DecodeOut decodeOut;
	WriteBack writeBack;

	PcCounter #(.XLEN(XLEN)) i_PcCounter (
		.clk(clk), .reset(reset), .pcOp(pcOp), .pcWriteData(pcWriteData), .pc(pc)
	);

	RegsFile #(.XLEN(XLEN)) i_RegsFile (
		.clk(clk), .reset(reset), .regNum0(regNum0), .regNum1(regNum1),
		.regReadData0(regReadData0), .regReadData1(regReadData1), .writeBack(writeBack)
	);

	Forward i_Forward (
		.regNum0(regNum0), .regNum1(regNum1), .execRd(execRd), .memRd(memRd),
		.wbRd(writeBack.rd), .fwdSel0(fwdSel0), .fwdSel1(fwdSel1)
	);

	Decode #(.XLEN(XLEN)) i_Decode (
		.clk(clk), .reset(reset), .instr(instr), .pc(pc), .flush(flush),
		.fwdSel0(fwdSel0), .fwdSel1(fwdSel1), .execResult(execResult),
		.memResult(memResult), .wbResult(writeBack.data), .regNum0(regNum0),
		.regNum1(regNum1), .regReadData0(regReadData0), .regReadData1(regReadData1),
		.decodeOut(decodeOut)
	);

	Execute #(.XLEN(XLEN)) i_Execute (
		.clk(clk), .reset(reset), .decodeOut(decodeOut), .memReadData(memReadData),
		.memAddr(memAddr), .memWriteData(memWriteData), .memWrite(memWrite),
		.memRead(memRead), .pcOp(pcOp), .pcWriteData(pcWriteData), .flush(flush),
		.execResult(execResult), .memResult(memResult), .execRd(execRd), .memRd(memRd),
		.writeBack(writeBack)
	);

endmodule

/* RiscCoreTb.sv */
`timescale 1ns/10ps
module RiscCoreTb;

	localparam int XLEN = 32;
	localparam int RomWords = 256;
	localparam int RamWords = 512;
	localparam int StoreTimeout = 40; // Cycles allowed until the next store
	localparam logic [31:0] MarkerAddr = 32'h0000_07f0;
	localparam logic [31:0] LoadAddr = 32'h0000_0300;
	localparam logic [31:0] DataBase = 32'h0000_0400;

	// RV32I major opcodes
	localparam logic [6:0] OpLoad = 7'b0000011;
	localparam logic [6:0] OpImm = 7'b0010011;
	localparam logic [6:0] OpAuipc = 7'b0010111;
	localparam logic [6:0] OpStore = 7'b0100011;
	localparam logic [6:0] OpReg = 7'b0110011;
	localparam logic [6:0] OpLui = 7'b0110111;
	localparam logic [6:0] OpBranch = 7'b1100011;
	localparam logic [6:0] OpJalr = 7'b1100111;
	localparam logic [6:0] OpJal = 7'b1101111;

	logic clk;
	logic reset;
	logic [XLEN-1:0] pc;
	logic [31:0] instr;
	logic [XLEN-1:0] memAddr;
	logic [XLEN-1:0] memWriteData;
	logic memWrite;
	logic memRead;
	logic [XLEN-1:0] memReadData;

	logic [31:0] rom [RomWords];
	logic [31:0] ram [RamWords];
	logic [31:0] opA;
	logic [31:0] opB;
	integer seed;
	int romPtr;
	int errorCount;
	int checkCount;
	int loadCount;
	logic [31:0] storeAddrQ [$]; // Stores seen on the data port
	logic [31:0] storeDataQ [$];
	logic [31:0] expAddrQ [$]; // Stores the program should make, in order
	logic [31:0] expDataQ [$];
	string expNameQ [$];
	string aluNames [10] = '{"add", "sub", "and", "or", "xor", "sll", "srl", "sra", "slt", "sltu"};

	RiscCore #(.XLEN(XLEN)) i_RiscCore (
		.clk(clk), .reset(reset), .pc(pc), .instr(instr), .memAddr(memAddr),
		.memWriteData(memWriteData), .memWrite(memWrite), .memRead(memRead),
		.memReadData(memReadData)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#50 clk = ~clk;
	end

	// ROM and data memory, driven on the falling edge
	always @(negedge clk)
	begin
		if (memWrite)
		begin
			storeAddrQ.push_back(memAddr);
			storeDataQ.push_back(memWriteData);
			ram[memAddr[10:2]] = memWriteData;
		end
		if (memRead)
			loadCount++;
		memReadData <= ram[memAddr[10:2]];
		instr <= rom[pc[9:2]];
	end

	resetQuiet: assert property (@(negedge clk) reset |-> (pc == '0 && !memWrite && !memRead))
		else
		begin
			errorCount++;
			$display("Reset: pc left zero or a memory strobe fired while reset was held");
		end

	// Squashed wrong-path stores go to the marker address
	noMarker: assert property (@(negedge clk) !(memWrite && memAddr == MarkerAddr))
		else
		begin
			errorCount++;
			$display("Branch: a squashed marker store reached the data port");
		end

	loadOnly: assert property (@(negedge clk) memRead |-> memAddr == LoadAddr)
		else
		begin
			errorCount++;
			$display("Load: memRead was high for an address other than the lw address");
		end

	function automatic logic [31:0] rFormat(input logic [6:0] func7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] func3, input logic [4:0] rd);
		return {func7, rs2, rs1, func3, rd, OpReg};
	endfunction

	function automatic logic [31:0] iFormat(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] func3, input logic [4:0] rd, input logic [6:0] opcode);
		return {imm, rs1, func3, rd, opcode};
	endfunction

	function automatic logic [31:0] sFormat(input logic [11:0] imm, input logic [4:0] rs2,
		input logic [4:0] rs1);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OpStore}; // sw only
	endfunction

	function automatic logic [31:0] bFormat(input logic [12:0] off, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] func3);
		return {off[12], off[10:5], rs2, rs1, func3, off[4:1], off[11], OpBranch};
	endfunction

	function automatic logic [31:0] uFormat(input logic [19:0] imm, input logic [4:0] rd,
		input logic [6:0] opcode);
		return {imm, rd, opcode};
	endfunction

	function automatic logic [31:0] jFormat(input logic [20:0] off, input logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, OpJal};
	endfunction

	// func7 and func3 of each ALU case, in aluNames order
	function automatic logic [9:0] aluFields(input int op);
		case (op)
			0: return {7'h00, 3'b000};
			1: return {7'h20, 3'b000};
			2: return {7'h00, 3'b111};
			3: return {7'h00, 3'b110};
			4: return {7'h00, 3'b100};
			5: return {7'h00, 3'b001};
			6: return {7'h00, 3'b101};
			7: return {7'h20, 3'b101};
			8: return {7'h00, 3'b010};
			default: return {7'h00, 3'b011};
		endcase
	endfunction

	function automatic logic [31:0] aluExpect(input int op, input logic [31:0] a,
		input logic [31:0] b);
		case (op)
			0: return a + b;
			1: return a - b;
			2: return a & b;
			3: return a | b;
			4: return a ^ b;
			5: return a << b[4:0];
			6: return a >> b[4:0];
			7: return $signed(a) >>> b[4:0];
			8: return {31'b0, $signed(a) < $signed(b)};
			default: return {31'b0, a < b};
		endcase
	endfunction

	function automatic logic branchTaken(input logic [2:0] func3, input logic [31:0] a,
		input logic [31:0] b);
		case (func3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	function automatic logic [31:0] regValue(input logic [4:0] num);
		return (num == 5'd1) ? opA : opB; // Branch operands live in x1 and x2
	endfunction

	task automatic emit(input logic [31:0] word);
		rom[romPtr] = word;
		romPtr++;
	endtask

	task automatic emitMarkers();
		emit(sFormat(MarkerAddr[11:0], 5'd31, 5'd0));
		emit(sFormat(MarkerAddr[11:0], 5'd31, 5'd0));
	endtask

	task automatic expectStore(input string name, input logic [31:0] addr,
		input logic [31:0] data);
		expNameQ.push_back(name);
		expAddrQ.push_back(addr);
		expDataQ.push_back(data);
	endtask

	task automatic loadConst(input logic [4:0] rd, input logic [31:0] value);
		logic [31:0] upper;
		upper = value + 32'h800; // Undo the sign of the low 12 bits
		emit(uFormat(upper[31:12], rd, OpLui));
		emit(iFormat(value[11:0], rd, 3'b000, rd, OpImm));
	endtask

	// Branch over two slots onto a target store
	task automatic branchBlock(input string name, input logic [2:0] func3,
		input logic [4:0] rs1, input logic [4:0] rs2, input int slot);
		logic [11:0] off;
		off = 12'h080 + 12'(slot * 16);
		emit(bFormat(13'd12, rs2, rs1, func3));
		if (branchTaken(func3, regValue(rs1), regValue(rs2)))
			emitMarkers();
		else
		begin
			emit(sFormat(off, 5'd2, 5'd10));
			expectStore({name, " fall 1"}, DataBase + 32'(off), opB);
			emit(sFormat(off + 12'd4, 5'd2, 5'd10));
			expectStore({name, " fall 2"}, DataBase + 32'(off) + 32'd4, opB);
		end
		emit(sFormat(off + 12'd8, 5'd1, 5'd10));
		expectStore({name, " target"}, DataBase + 32'(off) + 32'd8, opA);
	endtask

	task automatic buildProgram();
		logic [9:0] fields;
		logic [31:0] v4;
		logic [31:0] v5;
		logic [31:0] v6;
		logic [31:0] here;
		int op;
		romPtr = 0;
		emit(iFormat(DataBase[11:0], 5'd0, 3'b000, 5'd10, OpImm)); // x10 is the store base
		loadConst(5'd1, opA);
		loadConst(5'd2, opB);
		for (op = 0; op < 10; op++)
		begin
			fields = aluFields(op);
			emit(rFormat(fields[9:3], 5'd2, 5'd1, fields[2:0], 5'd3));
			emit(sFormat(12'(op * 4), 5'd3, 5'd10));
			expectStore(aluNames[op], DataBase + 32'(op * 4), aluExpect(op, opA, opB));
		end
		// Chain at distances one, two and three
		v4 = opA + 32'd17;
		v5 = v4 + opB;
		v6 = v4 ^ v5;
		emit(iFormat(12'd17, 5'd1, 3'b000, 5'd4, OpImm));
		emit(rFormat(7'h00, 5'd2, 5'd4, 3'b000, 5'd5));
		emit(rFormat(7'h00, 5'd5, 5'd4, 3'b100, 5'd6));
		emit(rFormat(7'h20, 5'd6, 5'd4, 3'b000, 5'd7));
		emit(sFormat(12'h040, 5'd5, 5'd10));
		emit(sFormat(12'h044, 5'd6, 5'd10));
		emit(sFormat(12'h048, 5'd7, 5'd10));
		expectStore("chain add", DataBase + 32'h40, v5);
		expectStore("chain xor", DataBase + 32'h44, v6);
		expectStore("chain sub", DataBase + 32'h48, v4 - v6);
		branchBlock("beq x1 x1", 3'b000, 5'd1, 5'd1, 0);
		branchBlock("beq x1 x2", 3'b000, 5'd1, 5'd2, 1);
		branchBlock("bne x1 x2", 3'b001, 5'd1, 5'd2, 2);
		branchBlock("bne x1 x1", 3'b001, 5'd1, 5'd1, 3);
		branchBlock("blt x1 x2", 3'b100, 5'd1, 5'd2, 4);
		branchBlock("blt x2 x1", 3'b100, 5'd2, 5'd1, 5);
		branchBlock("bgeu x1 x2", 3'b111, 5'd1, 5'd2, 6);
		branchBlock("bgeu x2 x1", 3'b111, 5'd2, 5'd1, 7);
		here = 32'(romPtr * 4);
		emit(jFormat(21'd12, 5'd11));
		emitMarkers();
		emit(sFormat(12'h100, 5'd11, 5'd10));
		expectStore("jal link", DataBase + 32'h100, here + 32'd4);
		here = 32'(romPtr * 4);
		emit(uFormat(20'h0, 5'd13, OpAuipc)); // x13 holds its own address
		emit(iFormat(12'd16, 5'd13, 3'b000, 5'd12, OpJalr));
		emitMarkers();
		emit(sFormat(12'h104, 5'd12, 5'd10));
		expectStore("jalr link", DataBase + 32'h104, here + 32'd8);
		emit(iFormat(LoadAddr[11:0], 5'd0, 3'b010, 5'd14, OpLoad));
		emit(iFormat(12'h000, 5'd0, 3'b000, 5'd0, OpImm)); // Spacer before the use
		emit(iFormat(12'h123, 5'd14, 3'b000, 5'd15, OpImm));
		emit(sFormat(12'h108, 5'd15, 5'd10));
		expectStore("lw use", DataBase + 32'h108, ram[LoadAddr[10:2]] + 32'h123);
		emit(jFormat(21'd0, 5'd0)); // Park in a self loop
	endtask

	task automatic nextStore(output logic [31:0] addr, output logic [31:0] data,
		output logic found);
		int waited;
		waited = 0;
		while (storeAddrQ.size() == 0 && waited < StoreTimeout)
		begin
			@(posedge clk);
			waited++;
		end
		found = storeAddrQ.size() > 0;
		addr = found ? storeAddrQ.pop_front() : '0;
		data = found ? storeDataQ.pop_front() : '0;
	endtask

	task automatic checkValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual == expected)
		else
		begin
			errorCount++;
			$display("Fail %s: expected %08h, actual %08h", name, expected, actual);
		end
	endtask

	initial
	begin
		logic [31:0] gotAddr;
		logic [31:0] gotData;
		logic found;
		int i;
		clk = 1'b0;
		reset = 1'b1;
		instr = '0;
		memReadData = '0;
		errorCount = 0;
		checkCount = 0;
		loadCount = 0;
		seed = 32'h850d_23a3;
		for (i = 0; i < RomWords; i++)
			rom[i] = iFormat(12'(i), 5'd0, 3'b000, 5'd0, OpImm); // Nop tagged with its index
		for (i = 0; i < RamWords; i++)
			ram[i] = 32'ha5a5_0000 ^ (32'(i) * 32'h0001_0101);
		opA = $random(seed);
		opB = $random(seed);
		buildProgram();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		checkValue("pc after reset", 32'd0, pc);
		checkValue("strobes after reset", 32'd0, {30'd0, memWrite, memRead});
		while (expAddrQ.size() > 0)
		begin
			nextStore(gotAddr, gotData, found);
			if (!found)
			begin
				errorCount++;
				$display("Timeout: store for %s never reached the data port", expNameQ[0]);
				break;
			end
			checkValue({expNameQ[0], " address"}, expAddrQ[0], gotAddr);
			checkValue({expNameQ[0], " data"}, expDataQ[0], gotData);
			void'(expNameQ.pop_front());
			void'(expAddrQ.pop_front());
			void'(expDataQ.pop_front());
		end
		repeat (20) @(posedge clk); // Core parks in its self loop
		checkCount++;
		assert (storeAddrQ.size() == 0)
		else
		begin
			errorCount++;
			$display("Idle: the core made a store after the last expected one");
		end
		checkValue("lw count", 32'd1, 32'(loadCount));
		$display("Checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule
